// File: common/mpf_edge_cfg.svh
/*
 * Sizing constants for the AFU-side write edge.
 * Include this header wherever heap depth, bus widths or the
 * almost-full slack are needed. The package takes its widths from here.
 */

`ifndef MPF_EDGE_CFG_SVH
`define MPF_EDGE_CFG_SVH

// Number of packet slots in the write-data heap
`define MPF_N_HEAP_ENTRIES 16

// Requests the AFU may still issue once it sees almost-full
`define MPF_ALM_FULL_THRESHOLD 2

// Longest multi-beat packet
`define MPF_MAX_BEATS 4

// Slots held back so in-flight requests and a whole packet still fit
`define MPF_MIN_FREE_SLOTS (`MPF_ALM_FULL_THRESHOLD + `MPF_MAX_BEATS + 1)

// Bus widths
`define MPF_ADDR_W 32
`define MPF_DATA_W 64

`endif

// File: common/mpf_edge_pkg.sv
/*
 * Shared types for the AFU-side write edge.
 * Modules and the testbench refer to these by scoped name.
 */

`include "mpf_edge_cfg.svh"

package mpf_edge_pkg;

    // Cache-line address of a request
    typedef logic [`MPF_ADDR_W-1:0] t_cl_addr;

    // One beat of write data
    typedef logic [`MPF_DATA_W-1:0] t_cl_data;

    // Beat count of a packet minus one
    typedef logic [$clog2(`MPF_MAX_BEATS)-1:0] t_cl_len;

    // Position of a beat inside its packet
    typedef logic [$clog2(`MPF_MAX_BEATS)-1:0] t_cl_num;

    // Slot index in the write-data heap
    typedef logic [$clog2(`MPF_N_HEAP_ENTRIES)-1:0] t_heap_idx;

    // Free slot count, wide enough to hold the full heap size
    typedef logic [$clog2(`MPF_N_HEAP_ENTRIES+1)-1:0] t_heap_cnt;

    // Heap control FSM
    // HEAP_INIT fills the free list after reset, HEAP_RUN serves requests
    typedef enum logic
    {
        HEAP_INIT,
        HEAP_RUN
    } t_heap_state;

endpackage

// File: heap/wr_heap_ctrl.sv
/*
 * Free-list allocator for write-data heap slots.
 * Fills a circular list with every index after reset, then hands
 * indices out at the head and takes returned ones in at the tail.
 */

`timescale 1ns/1ps

`include "mpf_edge_cfg.svh"

module wr_heap_ctrl
(
    input  logic                    clk,
    input  logic                    reset,

    // Take the slot at alloc_idx
    input  logic                    alloc,

    // Return a slot to the list
    input  logic                    free,
    input  mpf_edge_pkg::t_heap_idx free_idx,

    output mpf_edge_pkg::t_heap_idx alloc_idx,
    output logic                    not_full
);

    // Circular list of free slot indices
    mpf_edge_pkg::t_heap_idx free_list [`MPF_N_HEAP_ENTRIES];

    mpf_edge_pkg::t_heap_state state;
    mpf_edge_pkg::t_heap_idx   head;
    mpf_edge_pkg::t_heap_idx   tail;
    mpf_edge_pkg::t_heap_cnt   free_cnt;

    logic                      list_wen;
    mpf_edge_pkg::t_heap_idx   list_wdata;

    // The next slot is visible before it is consumed
    assign alloc_idx = free_list[head];

    // Keep a reserve so an open packet and the late almost-full can finish
    assign not_full = (state == mpf_edge_pkg::HEAP_RUN) &&
                      (free_cnt > mpf_edge_pkg::t_heap_cnt'(`MPF_MIN_FREE_SLOTS));

    // During init the tail walks the list and writes its own index
    always_comb
    begin
        if (state == mpf_edge_pkg::HEAP_INIT)
        begin
            list_wen   = 1'b1;
            list_wdata = tail;
        end
        else
        begin
            list_wen   = free;
            list_wdata = free_idx;
        end
    end

    always_ff @(posedge clk)
    begin
        if (list_wen)
        begin
            free_list[tail] <= list_wdata;
        end
    end

    // ====================
    // Pointers and count
    // ====================

    always_ff @(posedge clk)
    begin
        if (state == mpf_edge_pkg::HEAP_INIT)
        begin
            tail     <= tail + 1'b1;
            free_cnt <= free_cnt + 1'b1;

            // Last index written, the tail has wrapped back to the head
            if (tail == mpf_edge_pkg::t_heap_idx'(`MPF_N_HEAP_ENTRIES - 1))
            begin
                state <= mpf_edge_pkg::HEAP_RUN;
            end
        end
        else
        begin
            if (alloc)
            begin
                head <= head + 1'b1;
            end

            if (free)
            begin
                tail <= tail + 1'b1;
            end

            free_cnt <= free_cnt + mpf_edge_pkg::t_heap_cnt'(free)
                                 - mpf_edge_pkg::t_heap_cnt'(alloc);
        end

        if (reset)
        begin
            state    <= mpf_edge_pkg::HEAP_INIT;
            head     <= '0;
            tail     <= '0;
            free_cnt <= '0;
        end
    end

endmodule

// File: heap/wr_data_heap.sv
/*
 * Write-data storage for buffered packet beats.
 * Each heap slot holds up to a full packet, addressed by slot and beat.
 * Reads return data one cycle after the address is presented.
 */

`timescale 1ns/1ps

`include "mpf_edge_cfg.svh"

module wr_data_heap
(
    input  logic                    clk,

    // Write port fed by the AFU beats
    input  logic                    wen,
    input  mpf_edge_pkg::t_heap_idx widx,
    input  mpf_edge_pkg::t_cl_num   wbeat,
    input  mpf_edge_pkg::t_cl_data  wdata,

    // Read port used by downstream
    input  mpf_edge_pkg::t_heap_idx ridx,
    input  mpf_edge_pkg::t_cl_num   rbeat,
    output mpf_edge_pkg::t_cl_data  rdata
);

    localparam int DEPTH = `MPF_N_HEAP_ENTRIES * `MPF_MAX_BEATS;

    // Slot index in the upper bits, beat number in the lower bits
    mpf_edge_pkg::t_cl_data mem [DEPTH];

    always_ff @(posedge clk)
    begin
        if (wen)
        begin
            mem[{widx, wbeat}] <= wdata;
        end

        rdata <= mem[{ridx, rbeat}];
    end

endmodule

// File: src/wr_packet_track.sv
/*
 * Multi-beat write packet tracker.
 * Counts beats, restores the sop address and cl_len on later beats,
 * and registers one control flit when the last beat arrives.
 */

`timescale 1ns/1ps

module wr_packet_track
(
    input  logic                    clk,
    input  logic                    reset,

    // Incoming write beat
    input  logic                    wr_valid,
    input  logic                    wr_sop,
    input  mpf_edge_pkg::t_cl_len   wr_cl_len,
    input  mpf_edge_pkg::t_cl_addr  wr_addr,

    // Slot that the current packet will occupy
    input  mpf_edge_pkg::t_heap_idx alloc_idx,

    // Beat position and allocation strobe for the heap
    output mpf_edge_pkg::t_cl_num   beat_num,
    output logic                    heap_alloc,

    // Canonical control flit
    output logic                    req_valid,
    output mpf_edge_pkg::t_cl_addr  req_addr,
    output mpf_edge_pkg::t_cl_len   req_cl_len,
    output mpf_edge_pkg::t_heap_idx req_heap_idx
);

    // Beats already seen in the open packet
    mpf_edge_pkg::t_cl_num  beat_cnt;

    // Header fields captured on the sop beat
    mpf_edge_pkg::t_cl_addr sop_addr;
    mpf_edge_pkg::t_cl_len  sop_cl_len;

    // Header fields valid for the beat now on the input
    mpf_edge_pkg::t_cl_addr canon_addr;
    mpf_edge_pkg::t_cl_len  canon_cl_len;

    logic                   wr_eop;

    // ====================
    // Header recovery
    // ====================

    // Address and cl_len are don't-care on non-sop beats
    // so the saved sop values stand in for them
    always_comb
    begin
        if (wr_sop)
        begin
            beat_num     = '0;
            canon_addr   = wr_addr;
            canon_cl_len = wr_cl_len;
        end
        else
        begin
            beat_num     = beat_cnt;
            canon_addr   = sop_addr;
            canon_cl_len = sop_cl_len;
        end
    end

    // The last beat is the one whose position equals cl_len
    assign wr_eop     = wr_valid && (beat_num == canon_cl_len);
    assign heap_alloc = wr_eop;

    always_ff @(posedge clk)
    begin
        if (wr_valid && wr_sop)
        begin
            sop_addr   <= wr_addr;
            sop_cl_len <= wr_cl_len;
        end
    end

    // Restart counting after eop, otherwise step to the next beat
    always_ff @(posedge clk)
    begin
        if (wr_valid)
        begin
            beat_cnt <= wr_eop ? '0 : beat_num + 1'b1;
        end

        if (reset)
        begin
            beat_cnt <= '0;
        end
    end

    // ====================
    // Control flit
    // ====================

    // Only the final beat produces a flit, so all data is in the heap
    // by the time downstream sees it
    always_ff @(posedge clk)
    begin
        req_valid    <= wr_eop;
        req_addr     <= canon_addr;
        req_cl_len   <= canon_cl_len;
        req_heap_idx <= alloc_idx;

        if (reset)
        begin
            req_valid <= 1'b0;
        end
    end

endmodule

// File: src/mpf_edge_afu.sv
/*
 * AFU-side edge of the memory request pipeline.
 * Write beats from the AFU land in a local heap and a single control
 * flit per packet goes downstream. Downstream reads the beats back by
 * heap index and frees the slot when done.
 */

`timescale 1ns/1ps

module mpf_edge_afu
(
    input  logic                   clk,
    input  logic                   reset,

    // Write beats from the AFU
    input  logic                   afu_wr_valid,
    input  logic                   afu_wr_sop,
    input  mpf_edge_pkg::t_cl_len  afu_wr_cl_len,
    input  mpf_edge_pkg::t_cl_addr afu_wr_addr,
    input  mpf_edge_pkg::t_cl_data afu_wr_data,
    output logic                   afu_alm_full,

    // Control flit toward downstream
    input  logic                   fiu_alm_full,
    output logic                   fiu_req_valid,
    output mpf_edge_pkg::t_cl_addr fiu_req_addr,
    output mpf_edge_pkg::t_cl_len  fiu_req_cl_len,
    output mpf_edge_pkg::t_heap_idx fiu_req_heap_idx,

    // Heap read-back and slot release from downstream
    input  mpf_edge_pkg::t_heap_idx fiu_rd_idx,
    input  mpf_edge_pkg::t_cl_num  fiu_rd_beat,
    output mpf_edge_pkg::t_cl_data fiu_rd_data,
    input  logic                   fiu_free,
    input  mpf_edge_pkg::t_heap_idx fiu_free_idx
);

    logic                    heap_alloc;
    logic                    heap_not_full;
    mpf_edge_pkg::t_heap_idx alloc_idx;
    mpf_edge_pkg::t_cl_num   beat_num;

    // ====================
    // Packet tracking
    // ====================

    // Recovers sop header fields on later beats and emits the flit on eop
    wr_packet_track wr_packet_track_inst
    (
        .clk          (clk),
        .reset        (reset),
        .wr_valid     (afu_wr_valid),
        .wr_sop       (afu_wr_sop),
        .wr_cl_len    (afu_wr_cl_len),
        .wr_addr      (afu_wr_addr),
        .alloc_idx    (alloc_idx),
        .beat_num     (beat_num),
        .heap_alloc   (heap_alloc),
        .req_valid    (fiu_req_valid),
        .req_addr     (fiu_req_addr),
        .req_cl_len   (fiu_req_cl_len),
        .req_heap_idx (fiu_req_heap_idx)
    );

    // ====================
    // Heap
    // ====================

    // The slot is taken on the final beat, so every beat of a packet
    // writes into the same alloc_idx
    wr_heap_ctrl wr_heap_ctrl_inst
    (
        .clk       (clk),
        .reset     (reset),
        .alloc     (heap_alloc),
        .free      (fiu_free),
        .free_idx  (fiu_free_idx),
        .alloc_idx (alloc_idx),
        .not_full  (heap_not_full)
    );

    wr_data_heap wr_data_heap_inst
    (
        .clk   (clk),
        .wen   (afu_wr_valid),
        .widx  (alloc_idx),
        .wbeat (beat_num),
        .wdata (afu_wr_data),
        .ridx  (fiu_rd_idx),
        .rbeat (fiu_rd_beat),
        .rdata (fiu_rd_data)
    );

    // Almost-full toward the AFU is one cycle late
    // The reserved heap slots absorb the requests sent in that cycle
    always_ff @(posedge clk)
    begin
        afu_alm_full <= fiu_alm_full || !heap_not_full;

        if (reset)
        begin
            afu_alm_full <= 1'b1;
        end
    end

endmodule

// File: test/tb_mpf_edge_afu.sv
/*
 * Testbench for the AFU-side write edge.
 * Reads operations and expected values from test/mpf_edge_stimulus.txt,
 * drives them into the DUT one clock at a time and checks the control
 * flits, the heap read-back and almost-full against the file.
 */

`timescale 1ns/1ps

module tb_mpf_edge_afu;

    logic                    clk = 1'b0;
    logic                    reset;
    logic                    afu_wr_valid;
    logic                    afu_wr_sop;
    mpf_edge_pkg::t_cl_len   afu_wr_cl_len;
    mpf_edge_pkg::t_cl_addr  afu_wr_addr;
    mpf_edge_pkg::t_cl_data  afu_wr_data;
    logic                    afu_alm_full;
    logic                    fiu_alm_full;
    logic                    fiu_req_valid;
    mpf_edge_pkg::t_cl_addr  fiu_req_addr;
    mpf_edge_pkg::t_cl_len   fiu_req_cl_len;
    mpf_edge_pkg::t_heap_idx fiu_req_heap_idx;
    mpf_edge_pkg::t_heap_idx fiu_rd_idx;
    mpf_edge_pkg::t_cl_num   fiu_rd_beat;
    mpf_edge_pkg::t_cl_data  fiu_rd_data;
    logic                    fiu_free;
    mpf_edge_pkg::t_heap_idx fiu_free_idx;

    int fd;
    int n_lines;
    int cycle_cnt = 0;
    int cycle_limit = 100;
    int mismatches = 0;
    int test_mismatches = 0;
    int tests_run = 0;
    int tests_failed = 0;
    int other_errors = 0;

    mpf_edge_afu mpf_edge_afu_inst (.*);

    always #10 clk = ~clk;

    // ====================
    // Watchdog
    // ====================

    // The limit grows with the length of the stimulus file
    always @(posedge clk)
    begin
        cycle_cnt++;
        if (cycle_cnt >= cycle_limit)
        begin
            $display("Timeout after %0d cycles, the stimulus did not complete", cycle_cnt);
            $display("Simulation FAILED");
            $finish;
        end
    end

    // Inputs change and outputs are sampled 2 ns after the rising edge
    task automatic step_cycle();
        @(posedge clk);
        #2;
    endtask

    task automatic count_mismatch();
        mismatches++;
        test_mismatches++;
    endtask

    // A short read means the stimulus line is malformed
    task automatic verify_field_count(input string op, input int got, input int want);
        if (got != want)
        begin
            $display("Stimulus line %s has %0d fields where %0d are needed", op, got, want);
            other_errors++;
        end
    endtask

    // ====================
    // Compare tasks
    // ====================

    task automatic check_addr(input string name, input mpf_edge_pkg::t_cl_addr exp,
                              input mpf_edge_pkg::t_cl_addr act);
        if (exp !== act)
        begin
            $display("FAIL at %0t: %s expected %h, got %h", $time, name, exp, act);
            count_mismatch();
        end
    endtask

    task automatic check_len(input string name, input mpf_edge_pkg::t_cl_len exp,
                             input mpf_edge_pkg::t_cl_len act);
        if (exp !== act)
        begin
            $display("FAIL at %0t: %s expected %h, got %h", $time, name, exp, act);
            count_mismatch();
        end
    endtask

    task automatic check_idx(input string name, input mpf_edge_pkg::t_heap_idx exp,
                             input mpf_edge_pkg::t_heap_idx act);
        if (exp !== act)
        begin
            $display("FAIL at %0t: %s expected %h, got %h", $time, name, exp, act);
            count_mismatch();
        end
    endtask

    task automatic check_data(input string name, input mpf_edge_pkg::t_cl_data exp,
                              input mpf_edge_pkg::t_cl_data act);
        if (exp !== act)
        begin
            $display("FAIL at %0t: %s expected %h, got %h", $time, name, exp, act);
            count_mismatch();
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (exp !== act)
        begin
            $display("FAIL at %0t: %s expected %b, got %b", $time, name, exp, act);
            count_mismatch();
        end
    endtask

    // One summary line per test
    task automatic end_test(input string name);
        tests_run++;
        if (test_mismatches == 0)
            $display("Test %s passed", name);
        else
        begin
            tests_failed++;
            $display("Test %s failed with %0d mismatches", name, test_mismatches);
        end
        test_mismatches = 0;
    endtask

    // ====================
    // Main sequence
    // ====================

    initial
    begin
        string                   op;
        string                   line;
        string                   tname;
        logic                    sop;
        logic                    bit_val;
        mpf_edge_pkg::t_cl_len   len;
        mpf_edge_pkg::t_cl_addr  addr;
        mpf_edge_pkg::t_cl_data  data;
        mpf_edge_pkg::t_heap_idx idx;
        mpf_edge_pkg::t_cl_num   beat;
        int                      n;

        reset         = 1'b1;
        afu_wr_valid  = 1'b0;
        afu_wr_sop    = 1'b0;
        afu_wr_cl_len = '0;
        afu_wr_addr   = '0;
        afu_wr_data   = '0;
        fiu_alm_full  = 1'b0;
        fiu_rd_idx    = '0;
        fiu_rd_beat   = '0;
        fiu_free      = 1'b0;
        fiu_free_idx  = '0;

        fd = $fopen("test/mpf_edge_stimulus.txt", "r");
        if (fd == 0)
        begin
            $display("Could not open the stimulus file test/mpf_edge_stimulus.txt");
            other_errors++;
        end
        else
        begin
            n_lines = 0;
            while ($fgets(line, fd) != 0)
                n_lines++;
            cycle_limit = 4 * n_lines + 100;
            $fclose(fd);
            fd = $fopen("test/mpf_edge_stimulus.txt", "r");
        end

        // Almost-full must be up and no flit out while reset is held
        repeat (4) step_cycle();
        check_bit("afu_alm_full", 1'b1, afu_alm_full);
        check_bit("fiu_req_valid", 1'b0, fiu_req_valid);
        reset = 1'b0;
        end_test("reset_state");

        // The free list is rebuilt before the AFU may send anything
        while (afu_alm_full)
            step_cycle();

        if (fd != 0)
        begin
            while ($fscanf(fd, "%s", op) == 1)
            begin
                case (op)
                    "#": n = $fgets(line, fd);
                    "W":
                    begin
                        n = $fscanf(fd, "%h %h %h %h", sop, len, addr, data);
                        verify_field_count(op, n, 4);
                        afu_wr_valid  = 1'b1;
                        afu_wr_sop    = sop;
                        afu_wr_cl_len = len;
                        afu_wr_addr   = addr;
                        afu_wr_data   = data;
                        step_cycle();
                        afu_wr_valid  = 1'b0;
                        afu_wr_sop    = 1'b0;
                    end
                    "E":
                    begin
                        n = $fscanf(fd, "%h %h %h", addr, len, idx);
                        verify_field_count(op, n, 3);
                        check_bit("fiu_req_valid", 1'b1, fiu_req_valid);
                        check_addr("fiu_req_addr", addr, fiu_req_addr);
                        check_len("fiu_req_cl_len", len, fiu_req_cl_len);
                        check_idx("fiu_req_heap_idx", idx, fiu_req_heap_idx);
                    end
                    "N": check_bit("fiu_req_valid", 1'b0, fiu_req_valid);
                    "R":
                    begin
                        n = $fscanf(fd, "%h %h %h", idx, beat, data);
                        verify_field_count(op, n, 3);
                        fiu_rd_idx  = idx;
                        fiu_rd_beat = beat;
                        step_cycle();
                        check_data("fiu_rd_data", data, fiu_rd_data);
                    end
                    "F":
                    begin
                        n = $fscanf(fd, "%h", idx);
                        verify_field_count(op, n, 1);
                        fiu_free     = 1'b1;
                        fiu_free_idx = idx;
                        step_cycle();
                        fiu_free     = 1'b0;
                    end
                    "M":
                    begin
                        n = $fscanf(fd, "%h", bit_val);
                        verify_field_count(op, n, 1);
                        fiu_alm_full = bit_val;
                        step_cycle();
                    end
                    "A":
                    begin
                        n = $fscanf(fd, "%h", bit_val);
                        verify_field_count(op, n, 1);
                        check_bit("afu_alm_full", bit_val, afu_alm_full);
                    end
                    "T":
                    begin
                        n = $fscanf(fd, "%s", tname);
                        verify_field_count(op, n, 1);
                        end_test(tname);
                    end
                    default:
                    begin
                        $display("Unknown operation %s in the stimulus file", op);
                        other_errors++;
                    end
                endcase
            end
            $fclose(fd);
        end

        $display("Tests run %0d, passed %0d, failed %0d, mismatches %0d, other errors %0d",
                 tests_run, tests_run - tests_failed, tests_failed, mismatches, other_errors);
        if (tests_failed == 0 && mismatches == 0 && other_errors == 0)
            $display("Simulation PASSED");
        else
            $display("Simulation FAILED");
        $finish;
    end

endmodule

// File: test/mpf_edge_stimulus.txt
# W sop cl_len addr data | E addr cl_len idx | N | R idx beat data | F idx
# M fiu_alm_full | A afu_alm_full | T test_name   (all fields hex)
W 1 0 00001000 a5a5000000000001
E 00001000 0 0
T single_beat
W 1 3 00002000 b0b0000000000000
N
W 0 2 deadbeef b0b0000000000001
N
W 0 1 12345678 b0b0000000000002
N
W 0 0 ffffffff b0b0000000000003
E 00002000 3 1
T four_beat
R 0 0 a5a5000000000001
R 1 0 b0b0000000000000
R 1 1 b0b0000000000001
R 1 2 b0b0000000000002
R 1 3 b0b0000000000003
T read_back
M 1
A 1
M 0
A 0
T downstream_alm_full
F 1
F 0
W 1 0 00003000 c0c0000000000002
E 00003000 0 2
W 1 0 00003010 c0c0000000000003
W 1 0 00003020 c0c0000000000004
W 1 0 00003030 c0c0000000000005
W 1 0 00003040 c0c0000000000006
W 1 0 00003050 c0c0000000000007
W 1 0 00003060 c0c0000000000008
W 1 0 00003070 c0c0000000000009
W 1 0 00003080 c0c000000000000a
E 00003080 0 a
M 0
A 1
F 2
M 0
A 0
T heap_reserve
W 1 0 00004000 d0d000000000000b
F 3
F 4
W 1 0 00004010 d0d000000000000c
W 1 0 00004020 d0d000000000000d
F 5
F 6
W 1 0 00004030 d0d000000000000e
W 1 0 00004040 d0d000000000000f
E 00004040 0 f
F 7
F 8
W 1 0 00004050 d0d0000000000011
E 00004050 0 1
W 1 0 00004060 d0d0000000000010
E 00004060 0 0
T reuse_order

// File: mpf_edge_afu.f
+incdir+common
common/mpf_edge_pkg.sv
heap/wr_heap_ctrl.sv
heap/wr_data_heap.sv
src/wr_packet_track.sv
src/mpf_edge_afu.sv
test/tb_mpf_edge_afu.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Builds the testbench with Verilator and runs it from the project root
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/1ps -f mpf_edge_afu.f \
    --top-module tb_mpf_edge_afu -o tb_mpf_edge_afu || { echo "Build failed"; exit 1; }

sim_out="$(./obj_dir/tb_mpf_edge_afu)"
echo "$sim_out"
echo "$sim_out" | grep -q "^Simulation PASSED$" && exit 0 || exit 1
